//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_cplx_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cplx_pkg.sv
`default_nettype none

package cplx_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Each endpoint owns one 64 KB window
    localparam int WIN_W = 16;
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] FIFO_BASE = 32'h0002_0000;

    // Request opcode
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_e;

    // Response codes, same encoding as AXI RESP
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    // Sequencer FSM states
    typedef enum logic [1:0] {
        st_idle   = 2'b00,
        st_access = 2'b01,
        st_resp   = 2'b10
    } seq_state_e;

endpackage

`default_nettype wire

//--- cplx_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cplx_sequencer #(
    parameter int SRAM_AW = 6
) (
    input  wire logic                          core_clk,
    input  wire logic                          cptra_rst_b,
    input  wire logic                          i_req_valid,
    input  wire cplx_pkg::op_e                 i_req_op,
    input  wire logic [cplx_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire logic [cplx_pkg::DATA_W-1:0]   i_req_wdata,
    input  wire logic                          i_rsp_ready,
    input  wire logic                          i_err_en,
    input  wire logic [cplx_pkg::ADDR_W-1:0]   i_err_start,
    input  wire logic [cplx_pkg::ADDR_W-1:0]   i_err_end,
    input  wire logic                          i_fifo_full,
    input  wire logic                          i_fifo_empty,
    input  wire logic [cplx_pkg::DATA_W-1:0]   i_sram_rdata,
    input  wire logic [cplx_pkg::DATA_W-1:0]   i_fifo_rdata,
    output logic                               o_req_ready,
    output logic                               o_rsp_valid,
    output logic [cplx_pkg::DATA_W-1:0]        o_rsp_data,
    output cplx_pkg::resp_e                    o_rsp_resp,
    output logic                               o_sram_wr,
    output logic                               o_sram_rd,
    output logic [SRAM_AW-1:0]                 o_sram_idx,
    output logic                               o_fifo_push,
    output logic                               o_fifo_pop,
    output logic [cplx_pkg::DATA_W-1:0]        o_wdata
);

    localparam int ADDR_W = cplx_pkg::ADDR_W;
    localparam int WIN_W  = cplx_pkg::WIN_W;

    cplx_pkg::seq_state_e state_q;
    cplx_pkg::resp_e      resp_q;
    cplx_pkg::op_e        op_q;

    logic                        hit_sram_q;
    logic                        hit_fifo_q;
    logic                        inj_used_q;
    logic [cplx_pkg::DATA_W-1:0] wdata_q;
    logic [SRAM_AW-1:0]          idx_q;

    logic req_acc;
    logic in_sram;
    logic in_fifo;
    logic inject;
    logic fifo_reject;

    assign req_acc = i_req_valid && o_req_ready;

    // Window decode on the upper address bits
    assign in_sram = (i_req_addr[ADDR_W-1:WIN_W] == cplx_pkg::SRAM_BASE[ADDR_W-1:WIN_W]);
    assign in_fifo = (i_req_addr[ADDR_W-1:WIN_W] == cplx_pkg::FIFO_BASE[ADDR_W-1:WIN_W]);

    // One-shot injection, inclusive range
    assign inject = i_err_en && !inj_used_q &&
                    (i_req_addr >= i_err_start) && (i_req_addr <= i_err_end);

    // FIFO overflow or underflow is refused without a strobe
    assign fifo_reject = hit_fifo_q &&
                         (((op_q == cplx_pkg::op_write) && i_fifo_full) ||
                          ((op_q == cplx_pkg::op_read)  && i_fifo_empty));

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_q    <= cplx_pkg::st_idle;
            resp_q     <= cplx_pkg::resp_okay;
            hit_sram_q <= 1'b0;
            hit_fifo_q <= 1'b0;
            inj_used_q <= 1'b0;
        end else begin
            case (state_q)
                cplx_pkg::st_idle: begin
                    if (req_acc) begin
                        state_q    <= cplx_pkg::st_access;
                        hit_sram_q <= in_sram && !inject;
                        hit_fifo_q <= in_fifo && !inject;
                        if (inject) begin
                            resp_q     <= cplx_pkg::resp_slverr;
                            inj_used_q <= 1'b1;
                        end else if (in_sram || in_fifo) begin
                            resp_q <= cplx_pkg::resp_okay;
                        end else begin
                            resp_q <= cplx_pkg::resp_decerr;
                        end
                    end
                end
                cplx_pkg::st_access: begin
                    state_q <= cplx_pkg::st_resp;
                    if (fifo_reject) begin
                        resp_q <= cplx_pkg::resp_slverr;
                    end
                end
                cplx_pkg::st_resp: begin
                    if (i_rsp_ready) begin
                        state_q <= cplx_pkg::st_idle;
                    end
                end
                default: begin
                    state_q <= cplx_pkg::st_idle;
                end
            endcase
        end
    end

    // Request payload captured at acceptance
    always_ff @(posedge core_clk) begin
        if (req_acc) begin
            op_q    <= i_req_op;
            wdata_q <= i_req_wdata;
            idx_q   <= i_req_addr[2 +: SRAM_AW];
        end
    end

    assign o_req_ready = (state_q == cplx_pkg::st_idle);
    assign o_rsp_valid = (state_q == cplx_pkg::st_resp);

    // One strobe at most, only in the access cycle
    assign o_sram_wr   = (state_q == cplx_pkg::st_access) && hit_sram_q &&
                         (op_q == cplx_pkg::op_write);
    assign o_sram_rd   = (state_q == cplx_pkg::st_access) && hit_sram_q &&
                         (op_q == cplx_pkg::op_read);
    assign o_fifo_push = (state_q == cplx_pkg::st_access) && hit_fifo_q &&
                         (op_q == cplx_pkg::op_write) && !i_fifo_full;
    assign o_fifo_pop  = (state_q == cplx_pkg::st_access) && hit_fifo_q &&
                         (op_q == cplx_pkg::op_read) && !i_fifo_empty;

    assign o_sram_idx = idx_q;
    assign o_wdata    = wdata_q;

    // Read data only for successful reads
    assign o_rsp_data = (o_rsp_valid && (resp_q == cplx_pkg::resp_okay) &&
                         (op_q == cplx_pkg::op_read)) ?
                        (hit_sram_q ? i_sram_rdata : i_fifo_rdata) : '0;
    assign o_rsp_resp = resp_q;

endmodule

`default_nettype wire

//--- cplx_top.sv
`timescale 1ns/10ps
`default_nettype none

module cplx_top #(
    parameter int SRAM_AW = 6,
    parameter int FIFO_DW = 3
) (
    input  wire logic                          core_clk,
    input  wire logic                          cptra_rst_b,
    input  wire logic                          i_req_valid,
    input  wire cplx_pkg::op_e                 i_req_op,
    input  wire logic [cplx_pkg::ADDR_W-1:0]   i_req_addr,
    input  wire logic [cplx_pkg::DATA_W-1:0]   i_req_wdata,
    input  wire logic                          i_rsp_ready,
    input  wire logic                          i_err_en,
    input  wire logic [cplx_pkg::ADDR_W-1:0]   i_err_start,
    input  wire logic [cplx_pkg::ADDR_W-1:0]   i_err_end,
    input  wire logic                          i_fifo_clear,
    output logic                               o_req_ready,
    output logic                               o_rsp_valid,
    output logic [cplx_pkg::DATA_W-1:0]        o_rsp_data,
    output cplx_pkg::resp_e                    o_rsp_resp,
    output logic                               o_fifo_avail
);

    // Sequencer to endpoint strobes
    logic                        sram_wr;
    logic                        sram_rd;
    logic [SRAM_AW-1:0]          sram_idx;
    logic                        fifo_push;
    logic                        fifo_pop;
    logic [cplx_pkg::DATA_W-1:0] wdata;

    // Endpoint status and read data
    logic                        fifo_full;
    logic                        fifo_empty;
    logic [cplx_pkg::DATA_W-1:0] sram_rdata;
    logic [cplx_pkg::DATA_W-1:0] fifo_rdata;

    cplx_sequencer #(
        .SRAM_AW (SRAM_AW)
    ) u_seq (
        .core_clk     (core_clk),
        .cptra_rst_b  (cptra_rst_b),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_rsp_ready  (i_rsp_ready),
        .i_err_en     (i_err_en),
        .i_err_start  (i_err_start),
        .i_err_end    (i_err_end),
        .i_fifo_full  (fifo_full),
        .i_fifo_empty (fifo_empty),
        .i_sram_rdata (sram_rdata),
        .i_fifo_rdata (fifo_rdata),
        .o_req_ready  (o_req_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .o_rsp_resp   (o_rsp_resp),
        .o_sram_wr    (sram_wr),
        .o_sram_rd    (sram_rd),
        .o_sram_idx   (sram_idx),
        .o_fifo_push  (fifo_push),
        .o_fifo_pop   (fifo_pop),
        .o_wdata      (wdata)
    );

    sram_endpoint #(
        .SRAM_AW (SRAM_AW)
    ) u_sram (
        .core_clk (core_clk),
        .i_wr     (sram_wr),
        .i_rd     (sram_rd),
        .i_idx    (sram_idx),
        .i_wdata  (wdata),
        .o_rdata  (sram_rdata)
    );

    fifo_endpoint #(
        .FIFO_DW (FIFO_DW)
    ) u_fifo (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .i_push      (fifo_push),
        .i_pop       (fifo_pop),
        .i_clear     (i_fifo_clear),
        .i_wdata     (wdata),
        .o_rdata     (fifo_rdata),
        .o_full      (fifo_full),
        .o_empty     (fifo_empty),
        .o_avail     (o_fifo_avail)
    );

endmodule

`default_nettype wire

//--- fifo_endpoint.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_endpoint #(
    parameter int FIFO_DW = 3
) (
    input  wire logic                        core_clk,
    input  wire logic                        cptra_rst_b,
    input  wire logic                        i_push,
    input  wire logic                        i_pop,
    input  wire logic                        i_clear,
    input  wire logic [cplx_pkg::DATA_W-1:0] i_wdata,
    output logic [cplx_pkg::DATA_W-1:0]      o_rdata,
    output logic                             o_full,
    output logic                             o_empty,
    output logic                             o_avail
);

    localparam int DEPTH = 2 ** FIFO_DW;

    logic [cplx_pkg::DATA_W-1:0] mem [DEPTH];
    logic [FIFO_DW-1:0]          wr_ptr;
    logic [FIFO_DW-1:0]          rd_ptr;

    fifo_ptr_ctrl #(
        .FIFO_DW (FIFO_DW)
    ) u_ptr_ctrl (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .i_push      (i_push),
        .i_pop       (i_pop),
        .i_clear     (i_clear),
        .o_wr_ptr    (wr_ptr),
        .o_rd_ptr    (rd_ptr),
        .o_full      (o_full),
        .o_empty     (o_empty)
    );

    // Storage follows the same gating as the pointers
    always_ff @(posedge core_clk) begin
        if (i_push && !o_full && !i_clear) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    // Head entry captured on pop
    always_ff @(posedge core_clk) begin
        if (i_pop && !o_empty) begin
            o_rdata <= mem[rd_ptr];
        end
    end

    assign o_avail = !o_empty;

endmodule

`default_nettype wire

//--- fifo_ptr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_ptr_ctrl #(
    parameter int FIFO_DW = 3
) (
    input  wire logic         core_clk,
    input  wire logic         cptra_rst_b,
    input  wire logic         i_push,
    input  wire logic         i_pop,
    input  wire logic         i_clear,
    output logic [FIFO_DW-1:0] o_wr_ptr,
    output logic [FIFO_DW-1:0] o_rd_ptr,
    output logic              o_full,
    output logic              o_empty
);

    localparam logic [FIFO_DW:0] DEPTH = (FIFO_DW+1)'(2 ** FIFO_DW);

    logic [FIFO_DW:0] level_q;
    logic             do_push;
    logic             do_pop;

    // Ignore push when full and pop when empty
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            o_wr_ptr <= '0;
            o_rd_ptr <= '0;
            level_q  <= '0;
        end else if (i_clear) begin
            o_wr_ptr <= '0;
            o_rd_ptr <= '0;
            level_q  <= '0;
        end else begin
            // Pointers wrap naturally at the array size
            if (do_push) begin
                o_wr_ptr <= o_wr_ptr + 1'b1;
            end
            if (do_pop) begin
                o_rd_ptr <= o_rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    assign o_full  = (level_q == DEPTH);
    assign o_empty = (level_q == '0);

endmodule

`default_nettype wire

//--- sim.f
cplx_pkg.sv
fifo_ptr_ctrl.sv
sram_endpoint.sv
fifo_endpoint.sv
cplx_sequencer.sv
cplx_top.sv
tb_cplx_top.sv

//--- sram_endpoint.sv
`timescale 1ns/10ps
`default_nettype none

module sram_endpoint #(
    parameter int SRAM_AW = 6
) (
    input  wire logic                        core_clk,
    input  wire logic                        i_wr,
    input  wire logic                        i_rd,
    input  wire logic [SRAM_AW-1:0]          i_idx,
    input  wire logic [cplx_pkg::DATA_W-1:0] i_wdata,
    output logic [cplx_pkg::DATA_W-1:0]      o_rdata
);

    localparam int WORDS = 2 ** SRAM_AW;

    logic [cplx_pkg::DATA_W-1:0] mem [WORDS];

    // Known contents at simulation start
    initial begin
        mem = '{default: '0};
    end

    // Write lands on the strobe edge
    always_ff @(posedge core_clk) begin
        if (i_wr) begin
            mem[i_idx] <= i_wdata;
        end
    end

    // Registered read, data valid the edge after the strobe
    always_ff @(posedge core_clk) begin
        if (i_rd) begin
            o_rdata <= mem[i_idx];
        end
    end

endmodule

`default_nettype wire

//--- tb_cplx_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cplx_top;

    // Tests need about 400 cycles, the limit leaves plenty of margin
    localparam int MAX_CYCLES = 4000;

    logic                        core_clk;
    logic                        cptra_rst_b;
    logic                        i_req_valid;
    cplx_pkg::op_e               i_req_op;
    logic [cplx_pkg::ADDR_W-1:0] i_req_addr;
    logic [cplx_pkg::DATA_W-1:0] i_req_wdata;
    logic                        i_rsp_ready;
    logic                        i_err_en;
    logic [cplx_pkg::ADDR_W-1:0] i_err_start;
    logic [cplx_pkg::ADDR_W-1:0] i_err_end;
    logic                        i_fifo_clear;
    logic                        o_req_ready;
    logic                        o_rsp_valid;
    logic [cplx_pkg::DATA_W-1:0] o_rsp_data;
    cplx_pkg::resp_e             o_rsp_resp;
    logic                        o_fifo_avail;

    logic [31:0] lfsr_q;
    int          n_checks;
    int          n_errors;
    int          cycle_cnt;
    int          rsp_latency;
    logic        req_ready_after;
    string       test_name;

    cplx_top #(
        .SRAM_AW (6),
        .FIFO_DW (3)
    ) uut (
        .core_clk     (core_clk),
        .cptra_rst_b  (cptra_rst_b),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_rsp_ready  (i_rsp_ready),
        .i_err_en     (i_err_en),
        .i_err_start  (i_err_start),
        .i_err_end    (i_err_end),
        .i_fifo_clear (i_fifo_clear),
        .o_req_ready  (o_req_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .o_rsp_resp   (o_rsp_resp),
        .o_fifo_avail (o_fifo_avail)
    );

    always #2 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, label, exp, act);
        end
    endtask

    // One request and response, outputs sampled on the falling edge
    task automatic do_access(input cplx_pkg::op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input int stall,
                             output logic [31:0] data, output cplx_pkg::resp_e resp);
        logic rdy;
        @(posedge core_clk);
        i_req_valid <= 1'b1;
        i_req_op    <= op;
        i_req_addr  <= addr;
        i_req_wdata <= wdata;
        i_rsp_ready <= (stall == 0);
        do begin
            @(negedge core_clk);
            rdy = o_req_ready;
            @(posedge core_clk);
        end while (!rdy);
        i_req_valid <= 1'b0;
        // Count from the cycle in which the request was accepted
        rsp_latency = 1;
        @(negedge core_clk);
        while (!o_rsp_valid) begin
            @(posedge core_clk);
            rsp_latency++;
            @(negedge core_clk);
        end
        data = o_rsp_data;
        resp = o_rsp_resp;
        if (stall > 0) begin
            repeat (stall) begin
                @(posedge core_clk);
                @(negedge core_clk);
                check("valid held", 1, o_rsp_valid);
                check("data held", data, o_rsp_data);
                check("resp held", resp, o_rsp_resp);
                check("req_ready low", 0, o_req_ready);
            end
            @(posedge core_clk);
            i_rsp_ready <= 1'b1;
            @(negedge core_clk);
        end
        // Handshake edge
        @(posedge core_clk);
        @(negedge core_clk);
        req_ready_after = o_req_ready;
    endtask

    task automatic pulse_fifo_clear();
        @(posedge core_clk);
        i_fifo_clear <= 1'b1;
        @(posedge core_clk);
        i_fifo_clear <= 1'b0;
        @(negedge core_clk);
    endtask

    task automatic report_test(input int err_before);
        $display("%-24s %s, %0d errors", test_name,
                 (n_errors == err_before) ? "ok" : "bad", n_errors - err_before);
    endtask

    task automatic sram_round_trip();
        logic [31:0]     exp_mem [16];
        logic [31:0]     data;
        cplx_pkg::resp_e resp;
        int              err0;
        err0 = n_errors;
        test_name = "sram_round_trip";
        for (int i = 0; i < 16; i++) begin
            rand_word(exp_mem[i]);
            do_access(cplx_pkg::op_write, cplx_pkg::SRAM_BASE + 32'(i * 4), exp_mem[i], 0,
                      data, resp);
            check("write resp", cplx_pkg::resp_okay, resp);
            check("write data", 0, data);
        end
        for (int i = 0; i < 16; i++) begin
            do_access(cplx_pkg::op_read, cplx_pkg::SRAM_BASE + 32'(i * 4), 0, 0, data, resp);
            check("read resp", cplx_pkg::resp_okay, resp);
            check("read data", exp_mem[i], data);
        end
        report_test(err0);
    endtask

    task automatic fifo_order_and_flags();
        logic [31:0]     exp_q [8];
        logic [31:0]     data;
        cplx_pkg::resp_e resp;
        int              err0;
        err0 = n_errors;
        test_name = "fifo_order_and_flags";
        check("avail at start", 0, o_fifo_avail);
        for (int i = 0; i < 8; i++) begin
            rand_word(exp_q[i]);
            do_access(cplx_pkg::op_write, cplx_pkg::FIFO_BASE, exp_q[i], 0, data, resp);
            check("push resp", cplx_pkg::resp_okay, resp);
            check("avail after push", 1, o_fifo_avail);
        end
        do_access(cplx_pkg::op_write, cplx_pkg::FIFO_BASE, 32'hdead_beef, 0, data, resp);
        check("push when full", cplx_pkg::resp_slverr, resp);
        for (int i = 0; i < 8; i++) begin
            do_access(cplx_pkg::op_read, cplx_pkg::FIFO_BASE + 32'h10, 0, 0, data, resp);
            check("pop resp", cplx_pkg::resp_okay, resp);
            check("pop data", exp_q[i], data);
        end
        do_access(cplx_pkg::op_read, cplx_pkg::FIFO_BASE, 0, 0, data, resp);
        check("pop when empty", cplx_pkg::resp_slverr, resp);
        check("empty pop data", 0, data);
        check("avail when empty", 0, o_fifo_avail);
        // Clear drops a pending entry
        do_access(cplx_pkg::op_write, cplx_pkg::FIFO_BASE, 32'h1234_5678, 0, data, resp);
        check("push before clear", cplx_pkg::resp_okay, resp);
        pulse_fifo_clear();
        check("avail after clear", 0, o_fifo_avail);
        do_access(cplx_pkg::op_read, cplx_pkg::FIFO_BASE, 0, 0, data, resp);
        check("pop after clear", cplx_pkg::resp_slverr, resp);
        check("pop after clear data", 0, data);
        report_test(err0);
    endtask

    task automatic decode_error();
        logic [31:0]     data;
        cplx_pkg::resp_e resp;
        int              err0;
        err0 = n_errors;
        test_name = "decode_error";
        do_access(cplx_pkg::op_read, 32'h0003_0000, 0, 0, data, resp);
        check("read resp", cplx_pkg::resp_decerr, resp);
        check("read data", 0, data);
        do_access(cplx_pkg::op_write, 32'h0000_0040, 32'h5555_aaaa, 0, data, resp);
        check("write resp", cplx_pkg::resp_decerr, resp);
        check("write data", 0, data);
        report_test(err0);
    endtask

    task automatic error_injection();
        logic [31:0]     addr;
        logic [31:0]     val_a;
        logic [31:0]     val_b;
        logic [31:0]     data;
        cplx_pkg::resp_e resp;
        int              err0;
        err0 = n_errors;
        test_name = "error_injection";
        addr = cplx_pkg::SRAM_BASE + 32'h50;
        rand_word(val_a);
        rand_word(val_b);
        do_access(cplx_pkg::op_write, addr, val_a, 0, data, resp);
        check("setup resp", cplx_pkg::resp_okay, resp);
        @(posedge core_clk);
        i_err_start <= addr;
        i_err_end   <= addr + 32'd3;
        i_err_en    <= 1'b1;
        do_access(cplx_pkg::op_write, addr, val_b, 0, data, resp);
        check("injected resp", cplx_pkg::resp_slverr, resp);
        check("injected data", 0, data);
        do_access(cplx_pkg::op_read, addr, 0, 0, data, resp);
        check("unchanged resp", cplx_pkg::resp_okay, resp);
        check("unchanged data", val_a, data);
        do_access(cplx_pkg::op_write, addr, val_b, 0, data, resp);
        check("second write resp", cplx_pkg::resp_okay, resp);
        do_access(cplx_pkg::op_read, addr, 0, 0, data, resp);
        check("updated data", val_b, data);
        @(posedge core_clk);
        i_err_en <= 1'b0;
        report_test(err0);
    endtask

    task automatic timing_and_backpressure();
        logic [31:0]     val;
        logic [31:0]     data;
        cplx_pkg::resp_e resp;
        int              err0;
        err0 = n_errors;
        test_name = "timing_and_backpressure";
        rand_word(val);
        do_access(cplx_pkg::op_write, cplx_pkg::SRAM_BASE + 32'h80, val, 0, data, resp);
        check("write latency", 2, rsp_latency);
        check("ready after write", 1, req_ready_after);
        do_access(cplx_pkg::op_read, cplx_pkg::SRAM_BASE + 32'h80, 0, 5, data, resp);
        check("stalled latency", 2, rsp_latency);
        check("stalled resp", cplx_pkg::resp_okay, resp);
        check("stalled data", val, data);
        check("ready after stall", 1, req_ready_after);
        report_test(err0);
    endtask

    initial begin
        core_clk     = 1'b0;
        cptra_rst_b  = 1'b0;
        i_req_valid  = 1'b0;
        i_req_op     = cplx_pkg::op_read;
        i_req_addr   = '0;
        i_req_wdata  = '0;
        i_rsp_ready  = 1'b1;
        i_err_en     = 1'b0;
        i_err_start  = '0;
        i_err_end    = '0;
        i_fifo_clear = 1'b0;
        lfsr_q       = 32'h8b0246bc;
        n_checks     = 0;
        n_errors     = 0;
        cycle_cnt    = 0;
        repeat (4) @(posedge core_clk);
        cptra_rst_b <= 1'b1;
        @(negedge core_clk);
        sram_round_trip();
        fifo_order_and_flags();
        decode_error();
        error_injection();
        timing_and_backpressure();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
